/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_jal      = 7'b1101111;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_op_imm   = 7'b0010011;
    localparam logic [6:0] op_op       = 7'b0110011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;
    localparam logic [6:0] op_system   = 7'b1110011;

    localparam logic [6:0] funct7_zero = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // sub and sra.

    localparam logic [2:0] f3_add_sub = 3'd0;
    localparam logic [2:0] f3_sll     = 3'd1;
    localparam logic [2:0] f3_slt     = 3'd2;
    localparam logic [2:0] f3_sltu    = 3'd3;
    localparam logic [2:0] f3_xor     = 3'd4;
    localparam logic [2:0] f3_srl_sra = 3'd5;
    localparam logic [2:0] f3_or      = 3'd6;
    localparam logic [2:0] f3_and     = 3'd7;

    localparam logic [2:0] f3_beq  = 3'd0;
    localparam logic [2:0] f3_bne  = 3'd1;
    localparam logic [2:0] f3_blt  = 3'd4;
    localparam logic [2:0] f3_bge  = 3'd5;
    localparam logic [2:0] f3_bltu = 3'd6;
    localparam logic [2:0] f3_bgeu = 3'd7;

    // access width of loads and stores.
    localparam logic [2:0] f3_byte   = 3'd0;
    localparam logic [2:0] f3_half   = 3'd1;
    localparam logic [2:0] f3_word   = 3'd2;
    localparam logic [2:0] f3_byte_u = 3'd4;
    localparam logic [2:0] f3_half_u = 3'd5;

    localparam logic [2:0] f3_jalr  = 3'd0;
    localparam logic [2:0] f3_csrrw = 3'd1;
    localparam logic [2:0] f3_csrrs = 3'd2;

    localparam logic [31:0] sys_ecall   = 32'h0000_0073;
    localparam logic [31:0] sys_ebreak  = 32'h0010_0073;
    localparam logic [31:0] sys_mret    = 32'h3020_0073;
    localparam logic [31:0] sys_fence_i = 32'h0000_100f; // all register fields zero.

    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    localparam logic [11:0] csr_mepc      = 12'h341;
    localparam logic [11:0] csr_mcause    = 12'h342;
    localparam logic [11:0] csr_mvendorid = 12'hf11;
    localparam logic [11:0] csr_marchid   = 12'hf12;

endpackage

/* source/decode_pkg.sv */
package decode_pkg;

    localparam int alu_op_w    = 17;
    localparam int alu_op_add  = 0;
    localparam int alu_op_sub  = 1;
    localparam int alu_op_slt  = 2;
    localparam int alu_op_sltu = 3;
    localparam int alu_op_and  = 4;
    localparam int alu_op_or   = 5;
    localparam int alu_op_xor  = 6;
    localparam int alu_op_sll  = 7;
    localparam int alu_op_srl  = 8;
    localparam int alu_op_sra  = 9;
    localparam int alu_op_lui  = 10;
    localparam int alu_op_bne  = 11; // branch compares follow.
    localparam int alu_op_beq  = 12;
    localparam int alu_op_bge  = 13;
    localparam int alu_op_bgeu = 14;
    localparam int alu_op_blt  = 15;
    localparam int alu_op_bltu = 16;

    localparam int flag_w             = 15;
    localparam int flag_gpr_we        = 0;
    localparam int flag_load          = 1;
    localparam int flag_store         = 2;
    localparam int flag_load_unsigned = 3;
    localparam int flag_src1_pc       = 4;
    localparam int flag_src2_imm      = 5;
    localparam int flag_jump          = 6;
    localparam int flag_branch        = 7;
    localparam int flag_csrrw         = 8;
    localparam int flag_csrrs         = 9;
    localparam int flag_ecall         = 10;
    localparam int flag_mret          = 11;
    localparam int flag_ebreak        = 12;
    localparam int flag_fence_i       = 13;
    localparam int flag_illegal       = 14;

    localparam int                    mem_size_w = 2;
    localparam logic [mem_size_w-1:0] mem_byte   = 2'd0;
    localparam logic [mem_size_w-1:0] mem_half   = 2'd1;
    localparam logic [mem_size_w-1:0] mem_word   = 2'd2;

    localparam int csr_sel_w         = 6;
    localparam int csr_sel_mstatus   = 0;
    localparam int csr_sel_mtvec     = 1;
    localparam int csr_sel_mepc      = 2;
    localparam int csr_sel_mcause    = 3;
    localparam int csr_sel_mvendorid = 4;
    localparam int csr_sel_marchid   = 5;

endpackage

/* source/inst_decoder.sv */
module inst_decoder (
    input  logic [rv_isa_pkg::xlen-1:0]       inst,
    output logic [decode_pkg::alu_op_w-1:0]   alu_op,
    output logic [rv_isa_pkg::xlen-1:0]       imm,
    output logic [4:0]                        rd,
    output logic [decode_pkg::flag_w-1:0]     flags,
    output logic [decode_pkg::mem_size_w-1:0] mem_size,
    output logic [11:0]                       csr_addr,
    output logic [decode_pkg::csr_sel_w-1:0]  csr_sel
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    typedef enum logic [2:0] {fmt_none, fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j} fmt_e;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       legal;
    logic       csr_op;
    fmt_e       fmt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == funct7_alt);

    always_comb begin
        alu_op   = '0;
        flags    = '0;
        mem_size = '0;
        fmt      = fmt_none;
        legal    = 1'b0;
        case (opcode)
            op_lui: begin
                legal = 1'b1;
                fmt   = fmt_u;
                alu_op[alu_op_lui] = 1'b1;
                flags[flag_gpr_we] = 1'b1;
            end
            op_auipc: begin
                legal = 1'b1;
                fmt   = fmt_u;
                alu_op[alu_op_add]  = 1'b1;
                flags[flag_gpr_we]  = 1'b1;
                flags[flag_src1_pc] = 1'b1;
            end
            op_jal: begin
                legal = 1'b1;
                fmt   = fmt_j;
                alu_op[alu_op_add]  = 1'b1; // target is pc plus offset.
                flags[flag_gpr_we]  = 1'b1;
                flags[flag_src1_pc] = 1'b1;
                flags[flag_jump]    = 1'b1;
            end
            op_jalr: begin
                legal = (funct3 == f3_jalr);
                fmt   = fmt_i;
                alu_op[alu_op_add] = 1'b1;
                flags[flag_gpr_we] = 1'b1;
                flags[flag_jump]   = 1'b1;
            end
            op_branch: begin
                legal = 1'b1;
                fmt   = fmt_b;
                flags[flag_branch]  = 1'b1;
                flags[flag_src1_pc] = 1'b1;
                case (funct3)
                    f3_beq:  alu_op[alu_op_beq]  = 1'b1;
                    f3_bne:  alu_op[alu_op_bne]  = 1'b1;
                    f3_blt:  alu_op[alu_op_blt]  = 1'b1;
                    f3_bge:  alu_op[alu_op_bge]  = 1'b1;
                    f3_bltu: alu_op[alu_op_bltu] = 1'b1;
                    f3_bgeu: alu_op[alu_op_bgeu] = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            op_load: begin
                legal = 1'b1;
                fmt   = fmt_i;
                alu_op[alu_op_add] = 1'b1;
                flags[flag_gpr_we] = 1'b1;
                flags[flag_load]   = 1'b1;
                flags[flag_load_unsigned] = funct3[2];
                case (funct3)
                    f3_byte, f3_byte_u: mem_size = mem_byte;
                    f3_half, f3_half_u: mem_size = mem_half;
                    f3_word:            mem_size = mem_word;
                    default:            legal = 1'b0;
                endcase
            end
            op_store: begin
                legal = 1'b1;
                fmt   = fmt_s;
                alu_op[alu_op_add] = 1'b1;
                flags[flag_store]  = 1'b1;
                case (funct3)
                    f3_byte: mem_size = mem_byte;
                    f3_half: mem_size = mem_half;
                    f3_word: mem_size = mem_word;
                    default: legal = 1'b0;
                endcase
            end
            op_op_imm: begin
                legal = 1'b1;
                fmt   = fmt_i;
                flags[flag_gpr_we] = 1'b1;
                case (funct3)
                    f3_add_sub: alu_op[alu_op_add]  = 1'b1;
                    f3_slt:     alu_op[alu_op_slt]  = 1'b1;
                    f3_sltu:    alu_op[alu_op_sltu] = 1'b1;
                    f3_xor:     alu_op[alu_op_xor]  = 1'b1;
                    f3_or:      alu_op[alu_op_or]   = 1'b1;
                    f3_and:     alu_op[alu_op_and]  = 1'b1;
                    f3_sll: begin
                        alu_op[alu_op_sll] = 1'b1;
                        legal = (funct7 == funct7_zero);
                    end
                    f3_srl_sra: begin
                        alu_op[alt ? alu_op_sra : alu_op_srl] = 1'b1;
                        legal = (funct7 == funct7_zero) || alt;
                    end
                endcase
            end
            op_op: begin
                fmt = fmt_r;
                flags[flag_gpr_we] = 1'b1;
                legal = (funct7 == funct7_zero) ||
                        (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
                case (funct3)
                    f3_add_sub: alu_op[alt ? alu_op_sub : alu_op_add] = 1'b1;
                    f3_sll:     alu_op[alu_op_sll]  = 1'b1;
                    f3_slt:     alu_op[alu_op_slt]  = 1'b1;
                    f3_sltu:    alu_op[alu_op_sltu] = 1'b1;
                    f3_xor:     alu_op[alu_op_xor]  = 1'b1;
                    f3_srl_sra: alu_op[alt ? alu_op_sra : alu_op_srl] = 1'b1;
                    f3_or:      alu_op[alu_op_or]   = 1'b1;
                    f3_and:     alu_op[alu_op_and]  = 1'b1;
                endcase
            end
            op_misc_mem: begin
                legal = (inst == sys_fence_i);
                fmt   = fmt_i;
                flags[flag_fence_i] = 1'b1;
            end
            op_system: begin
                legal = 1'b1;
                if (funct3 == f3_csrrw || funct3 == f3_csrrs) begin
                    fmt = fmt_i;
                    flags[flag_gpr_we] = 1'b1; // old csr value goes to rd.
                    flags[flag_csrrw]  = (funct3 == f3_csrrw);
                    flags[flag_csrrs]  = (funct3 == f3_csrrs);
                end else if (inst == sys_ecall) begin
                    flags[flag_ecall] = 1'b1;
                    flags[flag_jump]  = 1'b1;
                end else if (inst == sys_mret) begin
                    flags[flag_mret] = 1'b1;
                    flags[flag_jump] = 1'b1;
                end else if (inst == sys_ebreak) begin
                    flags[flag_ebreak] = 1'b1;
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            alu_op   = '0;
            flags    = '0;
            mem_size = '0;
            fmt      = fmt_none;
            flags[flag_illegal] = 1'b1;
        end
        flags[flag_src2_imm] = (fmt != fmt_none) && (fmt != fmt_r);
    end

    always_comb begin
        case (fmt)
            fmt_i:   imm = {{(xlen-12){inst[31]}}, inst[31:20]};
            fmt_s:   imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};
            fmt_j:   imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign rd = flags[flag_gpr_we] ? inst[11:7] : 5'd0; // zero when nothing is written.

    assign csr_op   = flags[flag_csrrw] | flags[flag_csrrs] | flags[flag_ecall] | flags[flag_mret];
    assign csr_addr = csr_op ? inst[31:20] : 12'd0;

    assign csr_sel[csr_sel_mstatus]   = csr_op && (csr_addr == csr_mstatus);
    assign csr_sel[csr_sel_mtvec]     = csr_op && (csr_addr == csr_mtvec);
    assign csr_sel[csr_sel_mepc]      = csr_op && (csr_addr == csr_mepc);
    assign csr_sel[csr_sel_mcause]    = csr_op && (csr_addr == csr_mcause);
    assign csr_sel[csr_sel_mvendorid] = csr_op && (csr_addr == csr_mvendorid);
    assign csr_sel[csr_sel_marchid]   = csr_op && (csr_addr == csr_marchid);

endmodule

/* source/gpr_file.sv */
module gpr_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  rs1_idx,
    input  logic [4:0]                  rs2_idx,
    input  logic                        we,
    input  logic [4:0]                  wr_idx,
    input  logic [rv_isa_pkg::xlen-1:0] wr_data,
    output logic [rv_isa_pkg::xlen-1:0] rs1_data,
    output logic [rv_isa_pkg::xlen-1:0] rs2_data
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != 5'd0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // reads see the contents from before a write on the same edge.
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

/* source/decode_stage_reg.sv */
module decode_stage_reg (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    input  logic                                  flush,
    input  logic [rv_isa_pkg::xlen-1:0]           pc,
    input  logic [decode_pkg::alu_op_w-1:0]       alu_op,
    input  logic [rv_isa_pkg::xlen-1:0]           imm,
    input  logic [4:0]                            rd,
    input  logic [decode_pkg::flag_w-1:0]         flags,
    input  logic [decode_pkg::mem_size_w-1:0]     mem_size,
    input  logic [11:0]                           csr_addr,
    input  logic [decode_pkg::csr_sel_w-1:0]      csr_sel,
    input  logic [rv_isa_pkg::xlen-1:0]           src1,
    input  logic [rv_isa_pkg::xlen-1:0]           src2,
    output logic [rv_isa_pkg::xlen-1:0]           out_pc,
    output logic [decode_pkg::alu_op_w-1:0]       out_alu_op,
    output logic [rv_isa_pkg::xlen-1:0]           out_imm,
    output logic [4:0]                            out_rd,
    output logic [decode_pkg::flag_w-1:0]         out_flags,
    output logic [decode_pkg::mem_size_w-1:0]     out_mem_size,
    output logic [11:0]                           out_csr_addr,
    output logic [decode_pkg::csr_sel_w-1:0]      out_csr_sel,
    output logic [rv_isa_pkg::xlen-1:0]           out_src1,
    output logic [rv_isa_pkg::xlen-1:0]           out_src2
);

    assign in_ready = out_ready; // the stage stalls exactly when execute does.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid    <= 1'b0;
            out_pc       <= '0;
            out_alu_op   <= '0;
            out_imm      <= '0;
            out_rd       <= '0;
            out_flags    <= '0;
            out_mem_size <= '0;
            out_csr_addr <= '0;
            out_csr_sel  <= '0;
            out_src1     <= '0;
            out_src2     <= '0;
        end else if (out_ready) begin
            // a flushed instruction keeps its payload but loses its valid.
            out_valid    <= in_valid && !flush;
            out_pc       <= in_valid ? pc       : '0;
            out_alu_op   <= in_valid ? alu_op   : '0;
            out_imm      <= in_valid ? imm      : '0;
            out_rd       <= in_valid ? rd       : '0;
            out_flags    <= in_valid ? flags    : '0;
            out_mem_size <= in_valid ? mem_size : '0;
            out_csr_addr <= in_valid ? csr_addr : '0;
            out_csr_sel  <= in_valid ? csr_sel  : '0;
            out_src1     <= in_valid ? src1     : '0;
            out_src2     <= in_valid ? src2     : '0;
        end
    end

endmodule

/* source/decode_unit.sv */
module decode_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetch_valid,
    output logic                              fetch_ready,
    input  logic [rv_isa_pkg::xlen-1:0]       fetch_pc,
    input  logic [rv_isa_pkg::xlen-1:0]       fetch_inst,
    output logic                              dec_valid,
    input  logic                              exec_ready,
    input  logic                              flush,
    output logic [rv_isa_pkg::xlen-1:0]       dec_pc,
    output logic [rv_isa_pkg::xlen-1:0]       dec_imm,
    output logic [rv_isa_pkg::xlen-1:0]       dec_src1,
    output logic [rv_isa_pkg::xlen-1:0]       dec_src2,
    output logic [4:0]                        dec_rd,
    output logic [decode_pkg::alu_op_w-1:0]   dec_alu_op,
    output logic [decode_pkg::flag_w-1:0]     dec_flags,
    output logic [decode_pkg::mem_size_w-1:0] dec_mem_size,
    output logic [11:0]                       dec_csr_addr,
    output logic [decode_pkg::csr_sel_w-1:0]  dec_csr_sel,
    input  logic                              wb_we,
    input  logic [4:0]                        wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_data
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [alu_op_w-1:0]   id_alu_op;
    logic [xlen-1:0]       id_imm;
    logic [4:0]            id_rd;
    logic [flag_w-1:0]     id_flags;
    logic [mem_size_w-1:0] id_mem_size;
    logic [11:0]           id_csr_addr;
    logic [csr_sel_w-1:0]  id_csr_sel;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    inst_decoder dec0 (
        .inst     (fetch_inst),
        .alu_op   (id_alu_op),
        .imm      (id_imm),
        .rd       (id_rd),
        .flags    (id_flags),
        .mem_size (id_mem_size),
        .csr_addr (id_csr_addr),
        .csr_sel  (id_csr_sel)
    );

    gpr_file gpr0 (
        .clk      (clk),
        .rst      (rst),
        .rs1_idx  (fetch_inst[19:15]),
        .rs2_idx  (fetch_inst[24:20]),
        .we       (wb_we),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_stage_reg sreg0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (fetch_valid),
        .in_ready     (fetch_ready),
        .out_valid    (dec_valid),
        .out_ready    (exec_ready),
        .flush        (flush),
        .pc           (fetch_pc),
        .alu_op       (id_alu_op),
        .imm          (id_imm),
        .rd           (id_rd),
        .flags        (id_flags),
        .mem_size     (id_mem_size),
        .csr_addr     (id_csr_addr),
        .csr_sel      (id_csr_sel),
        .src1         (rs1_data),
        .src2         (rs2_data),
        .out_pc       (dec_pc),
        .out_alu_op   (dec_alu_op),
        .out_imm      (dec_imm),
        .out_rd       (dec_rd),
        .out_flags    (dec_flags),
        .out_mem_size (dec_mem_size),
        .out_csr_addr (dec_csr_addr),
        .out_csr_sel  (dec_csr_sel),
        .out_src1     (dec_src1),
        .out_src2     (dec_src2)
    );

endmodule

/* sim/decode_ref_model.svh */
`ifndef decode_ref_model_svh
`define decode_ref_model_svh

typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [alu_op_w-1:0]   alu_op;
    logic [xlen-1:0]       imm;
    logic [4:0]            rd;
    logic [flag_w-1:0]     flags;
    logic [mem_size_w-1:0] mem_size;
    logic [11:0]           csr_addr;
    logic [csr_sel_w-1:0]  csr_sel;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
} entry_t;

logic [31:0]     lcg_state = 32'h1e726522;
logic [xlen-1:0] shadow [0:31]; // architectural view of the register file.

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// returns a mostly legal encoding with random fields. One class in sixteen is raw noise.
function automatic logic [31:0] gen_inst();
    logic [31:0] r;
    logic [31:0] f;
    logic [6:0]  f7;
    logic [11:0] csr;
    r  = lcg_next();
    f  = lcg_next();
    f7 = r[20] ? funct7_alt : funct7_zero;
    case (r[24:22])
        3'd0:    csr = csr_mstatus;
        3'd1:    csr = csr_mtvec;
        3'd2:    csr = csr_mepc;
        3'd3:    csr = csr_mcause;
        3'd4:    csr = csr_mvendorid;
        3'd5:    csr = csr_marchid;
        default: csr = f[31:20];
    endcase
    case (r[31:28])
        4'd0:        return {f[31:7], op_lui};
        4'd1:        return {f[31:7], op_auipc};
        4'd2:        return {f[31:7], op_jal};
        4'd3:        return {f[31:15], f3_jalr, f[11:7], op_jalr};
        4'd4:        return {f[31:7], op_branch}; // funct3 of 2 and 3 is illegal here.
        4'd5:        return {f[31:7], op_load};
        4'd6:        return {f[31:7], op_store};
        4'd7, 4'd8:  return {(f[13:12] == 2'b01) ? f7 : f[31:25], f[24:7], op_op_imm};
        4'd9, 4'd10: return {f7, f[24:7], op_op};
        4'd11, 4'd12: begin
            return {csr, f[19:15], r[21] ? f3_csrrs : f3_csrrw, f[11:7], op_system};
        end
        4'd13: begin
            return r[22] ? (r[21] ? sys_fence_i : sys_mret) : (r[21] ? sys_ebreak : sys_ecall);
        end
        4'd14:       return {f[31:15], f3_and, f[11:7], op_op_imm};
        default:     return f;
    endcase
endfunction

function automatic int alu_index(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? alu_op_sub : alu_op_add;
        3'd1:    return alu_op_sll;
        3'd2:    return alu_op_slt;
        3'd3:    return alu_op_sltu;
        3'd4:    return alu_op_xor;
        3'd5:    return alt ? alu_op_sra : alu_op_srl;
        3'd6:    return alu_op_or;
        default: return alu_op_and;
    endcase
endfunction

// the caller fills in pc and operands of the expected entry.
function automatic entry_t ref_decode(input logic [31:0] inst);
    entry_t     e;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    logic       csr;
    int         kind; // 0 none, 1 r, 2 i, 3 s, 4 b, 5 u, 6 j.
    e    = '0;
    f3   = inst[14:12];
    f7   = inst[31:25];
    ok   = 1'b1;
    kind = 2;
    case (inst[6:0])
        op_lui: begin
            kind = 5;
            e.alu_op[alu_op_lui] = 1'b1;
            e.flags[flag_gpr_we] = 1'b1;
        end
        op_auipc, op_jal: begin
            kind = (inst[6:0] == op_jal) ? 6 : 5;
            e.alu_op[alu_op_add]  = 1'b1;
            e.flags[flag_gpr_we]  = 1'b1;
            e.flags[flag_src1_pc] = 1'b1;
            e.flags[flag_jump]    = (inst[6:0] == op_jal);
        end
        op_jalr: begin
            ok = (f3 == f3_jalr);
            e.alu_op[alu_op_add] = 1'b1;
            e.flags[flag_gpr_we] = 1'b1;
            e.flags[flag_jump]   = 1'b1;
        end
        op_branch: begin
            kind = 4;
            e.flags[flag_branch]  = 1'b1;
            e.flags[flag_src1_pc] = 1'b1;
            case (f3)
                f3_beq:  e.alu_op[alu_op_beq]  = 1'b1;
                f3_bne:  e.alu_op[alu_op_bne]  = 1'b1;
                f3_blt:  e.alu_op[alu_op_blt]  = 1'b1;
                f3_bge:  e.alu_op[alu_op_bge]  = 1'b1;
                f3_bltu: e.alu_op[alu_op_bltu] = 1'b1;
                f3_bgeu: e.alu_op[alu_op_bgeu] = 1'b1;
                default: ok = 1'b0;
            endcase
        end
        op_load, op_store: begin
            kind = (inst[6:0] == op_store) ? 3 : 2;
            ok   = (inst[6:0] == op_store) ? (f3 < 3'd3) : (f3 != 3'd3 && f3 < 3'd6);
            e.alu_op[alu_op_add]        = 1'b1;
            e.flags[flag_gpr_we]        = (inst[6:0] == op_load);
            e.flags[flag_load]          = (inst[6:0] == op_load);
            e.flags[flag_store]         = (inst[6:0] == op_store);
            e.flags[flag_load_unsigned] = (inst[6:0] == op_load) && f3[2];
            e.mem_size = (f3[1:0] == 2'd0) ? mem_byte : (f3[1:0] == 2'd1) ? mem_half : mem_word;
        end
        op_op_imm: begin
            ok = (f3 == f3_sll) ? (f7 == funct7_zero) :
                 (f3 == f3_srl_sra) ? (f7 == funct7_zero || f7 == funct7_alt) : 1'b1;
            e.alu_op[alu_index(f3, f3 == f3_srl_sra && f7 == funct7_alt)] = 1'b1;
            e.flags[flag_gpr_we] = 1'b1;
        end
        op_op: begin
            kind = 1;
            ok   = (f7 == funct7_zero) ||
                   (f7 == funct7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra));
            e.alu_op[alu_index(f3, f7 == funct7_alt)] = 1'b1;
            e.flags[flag_gpr_we] = 1'b1;
        end
        op_misc_mem: begin
            ok = (inst == sys_fence_i);
            e.flags[flag_fence_i] = 1'b1;
        end
        op_system: begin
            kind = 0;
            if (f3 == f3_csrrw || f3 == f3_csrrs) begin
                kind = 2;
                e.flags[flag_gpr_we] = 1'b1;
                e.flags[flag_csrrw]  = (f3 == f3_csrrw);
                e.flags[flag_csrrs]  = (f3 == f3_csrrs);
            end else if (inst == sys_ecall || inst == sys_mret) begin
                e.flags[flag_ecall] = (inst == sys_ecall);
                e.flags[flag_mret]  = (inst == sys_mret);
                e.flags[flag_jump]  = 1'b1;
            end else begin
                ok = (inst == sys_ebreak);
                e.flags[flag_ebreak] = 1'b1;
            end
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        e    = '0;
        kind = 0;
        e.flags[flag_illegal] = 1'b1;
    end
    e.flags[flag_src2_imm] = (kind >= 2);
    case (kind)
        2:       e.imm = {{20{inst[31]}}, inst[31:20]};
        3:       e.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        4:       e.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        5:       e.imm = {inst[31:12], 12'b0};
        6:       e.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        default: e.imm = '0;
    endcase
    if (e.flags[flag_gpr_we]) begin
        e.rd = inst[11:7];
    end
    csr = e.flags[flag_csrrw] | e.flags[flag_csrrs] | e.flags[flag_ecall] | e.flags[flag_mret];
    if (csr) begin
        e.csr_addr = inst[31:20];
        e.csr_sel[csr_sel_mstatus]   = (inst[31:20] == csr_mstatus);
        e.csr_sel[csr_sel_mtvec]     = (inst[31:20] == csr_mtvec);
        e.csr_sel[csr_sel_mepc]      = (inst[31:20] == csr_mepc);
        e.csr_sel[csr_sel_mcause]    = (inst[31:20] == csr_mcause);
        e.csr_sel[csr_sel_mvendorid] = (inst[31:20] == csr_mvendorid);
        e.csr_sel[csr_sel_marchid]   = (inst[31:20] == csr_marchid);
    end
    return e;
endfunction

`endif

/* sim/tb_decode_unit.sv */
module tb_decode_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    logic                  fetch_ready;
    logic [xlen-1:0]       fetch_pc;
    logic [xlen-1:0]       fetch_inst;
    logic                  exec_ready;
    logic                  flush;
    logic                  wb_we;
    logic [4:0]            wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  dec_valid;
    logic [xlen-1:0]       dec_pc;
    logic [xlen-1:0]       dec_imm;
    logic [xlen-1:0]       dec_src1;
    logic [xlen-1:0]       dec_src2;
    logic [4:0]            dec_rd;
    logic [alu_op_w-1:0]   dec_alu_op;
    logic [flag_w-1:0]     dec_flags;
    logic [mem_size_w-1:0] dec_mem_size;
    logic [11:0]           dec_csr_addr;
    logic [csr_sel_w-1:0]  dec_csr_sel;
    int                    errors = 0;
    int                    checks = 0;

    `include "decode_ref_model.svh"

    entry_t expq [$];
    entry_t cur;

    decode_unit dut0 (.*);

    always #4 clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs(input entry_t e);
        check_field("dec_valid", 32'(dec_valid), 32'(e.valid));
        check_field("dec_pc", dec_pc, e.pc);
        check_field("dec_alu_op", 32'(dec_alu_op), 32'(e.alu_op));
        check_field("dec_imm", dec_imm, e.imm);
        check_field("dec_rd", 32'(dec_rd), 32'(e.rd));
        check_field("dec_flags", 32'(dec_flags), 32'(e.flags));
        check_field("dec_mem_size", 32'(dec_mem_size), 32'(e.mem_size));
        check_field("dec_csr_addr", 32'(dec_csr_addr), 32'(e.csr_addr));
        check_field("dec_csr_sel", 32'(dec_csr_sel), 32'(e.csr_sel));
        check_field("dec_src1", dec_src1, e.src1);
        check_field("dec_src2", dec_src2, e.src2);
    endtask

    task automatic wait_for_valid(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!dec_valid && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!dec_valid) begin
            errors++;
            $display("dec_valid did not rise within %0d cycles of a transfer", max_cycles + 1);
        end else if (n != 0) begin
            errors++;
            $display("dec_valid rose %0d cycles later than one cycle after a transfer", n);
        end
    endtask

    // drives one clock of stimulus between two falling edges.
    task automatic step(input logic [31:0] inst, input logic valid, input logic ready,
                        input logic kill, input logic we, input logic [4:0] wrd);
        entry_t e;
        e           = '0;
        fetch_inst  = inst;
        fetch_valid = valid;
        fetch_pc    = lcg_next() & 32'hffff_fffc;
        exec_ready  = ready;
        flush       = kill;
        wb_we       = we;
        wb_rd       = wrd;
        wb_data     = lcg_next();
        #1;
        check_field("fetch_ready", 32'(fetch_ready), 32'(ready));
        if (ready) begin
            if (valid) begin
                e      = ref_decode(inst);
                e.pc   = fetch_pc;
                e.src1 = shadow[inst[19:15]]; // operands come from before this edge's write.
                e.src2 = shadow[inst[24:20]];
            end
            e.valid = valid && !kill;
            expq.push_back(e);
        end
        @(posedge clk);
        if (we && wrd != 5'd0) begin
            shadow[wrd] = wb_data;
        end
        if (ready && e.valid) begin
            wait_for_valid(3);
        end else begin
            @(negedge clk);
        end
        if (ready) begin
            cur = expq.pop_front();
        end
        compare_outputs(cur);
    endtask

    task automatic report_and_stop();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        #100us;
        $display("simulation did not finish within its time limit");
        errors++;
        report_and_stop();
    end

    initial begin
        logic [31:0] r;
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst  = '0;
        exec_ready  = 1'b0;
        flush       = 1'b0;
        wb_we       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        cur         = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_outputs(cur);
        for (int i = 0; i < 16; i++) begin // every register reads zero after reset.
            step({funct7_zero, 5'(2 * i + 1), 5'(2 * i), f3_add_sub, 5'(i), op_op},
                 1'b1, 1'b1, 1'b0, 1'b0, 5'd0);
        end
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            step(gen_inst(), r[31:29] != 3'd0, r[28:26] != 3'd0, r[25:22] == 4'd0,
                 r[21], r[20:16]);
        end
        step(gen_inst(), 1'b1, 1'b1, 1'b0, 1'b1, 5'd0); // x0 ignores this write.
        step({funct7_zero, 5'd0, 5'd0, f3_or, 5'd1, op_op}, 1'b1, 1'b1, 1'b0, 1'b0, 5'd0);
        for (int n = 0; n < 5; n++) begin
            r = lcg_next();
            step(gen_inst(), r[30], 1'b0, r[29], r[28], r[20:16]);
        end
        step(gen_inst(), 1'b1, 1'b1, 1'b1, 1'b0, 5'd0);
        step(gen_inst(), 1'b0, 1'b1, 1'b0, 1'b0, 5'd0);
        report_and_stop();
    end

endmodule

/* filelist.f */
+incdir+sim
source/rv_isa_pkg.sv
source/decode_pkg.sv
source/inst_decoder.sv
source/gpr_file.sv
source/decode_stage_reg.sv
source/decode_unit.sv
sim/tb_decode_unit.sv

/* Bender.yml */
package:
  name: decode_unit

sources:
  - source/rv_isa_pkg.sv
  - source/decode_pkg.sv
  - source/inst_decoder.sv
  - source/gpr_file.sv
  - source/decode_stage_reg.sv
  - source/decode_unit.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_decode_unit.sv
